/* noc_pkg.sv */
package noc_pkg;

  // ========================================
  // packet layout
  // ========================================

  // one ring packet is three bus words
  localparam int unsigned packet_w  = 96;
  localparam int unsigned bus_w     = 32;
  localparam int unsigned node_id_w = 6;

  // receiver id field
  localparam int unsigned rid_hi = 95;
  localparam int unsigned rid_lo = 90;

  // transmitter id field
  localparam int unsigned tid_hi = 89;
  localparam int unsigned tid_lo = 84;

  // set on acknowledge packets
  localparam int unsigned ack_bit = 83;

  // bits 82 to 0 carry payload, untouched by hardware

  // receiver id 0 marks an empty slot, nodes count from 1
  localparam logic [node_id_w-1:0] id_empty     = 6'd0;
  // general broadcast receiver
  localparam logic [node_id_w-1:0] id_broadcast = 6'd63;

  typedef logic [packet_w-1:0] packet_t;

  // ========================================
  // register map
  // ========================================

  // word offset lives in address bits 4 to 2
  localparam int unsigned reg_adr_hi = 4;
  localparam int unsigned reg_adr_lo = 2;

  localparam logic [2:0] reg_word0  = 3'd0;
  localparam logic [2:0] reg_word1  = 3'd1;
  localparam logic [2:0] reg_word2  = 3'd2;
  // write starts a transmit, read pops the queue
  localparam logic [2:0] reg_cmd    = 3'd6;
  localparam logic [2:0] reg_status = 3'd7;

  // status word fields
  localparam int unsigned st_id_hi   = 31;
  localparam int unsigned st_id_lo   = 26;
  localparam int unsigned st_txp_bit = 25;
  localparam int unsigned st_cnt_w   = 6;

  // receive queue size
  localparam int unsigned queue_depth_default = 64;

endpackage

/* noc_delay_line.sv */
`timescale 1ns/1ps

module noc_delay_line #(
  parameter int unsigned WIDTH = 96,
  parameter int unsigned DEPTH = 64
) (
  input  logic                     clk_i,
  input  logic                     ce_i,
  input  logic [$clog2(DEPTH)-1:0] tap_i,
  input  logic [WIDTH-1:0]         d_i,
  output logic [WIDTH-1:0]         q_o
);

  // ========================================
  // shift stages
  // ========================================

  // plain storage, contents are don't care until written
  logic [WIDTH-1:0] stage_q [DEPTH];

  // whole line moves one step per enable
  // newest word always lands in stage 0
  always_ff @(posedge clk_i) begin
    if (ce_i) begin
      stage_q[0] <= d_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // ========================================
  // read tap
  // ========================================

  // tap 0 is the newest entry, higher taps are older
  assign q_o = stage_q[tap_i];

endmodule

/* noc_node_ctrl.sv */
`timescale 1ns/1ps

module noc_node_ctrl #(
  parameter int unsigned NODE_ID     = 1,
  parameter int unsigned QUEUE_DEPTH = noc_pkg::queue_depth_default
) (
  input  logic             clk_i,
  input  logic             rst_i,
  // register bus
  input  logic             bus_cyc_i,
  input  logic             bus_stb_i,
  input  logic             bus_cs_i,
  input  logic             bus_we_i,
  input  logic [31:0]      bus_adr_i,
  input  logic [31:0]      bus_dat_i,
  output logic             bus_ack_o,
  output logic [31:0]      bus_dat_o,
  // ring stage
  input  noc_pkg::packet_t net_i,
  output noc_pkg::packet_t net_o
);

  import noc_pkg::*;

  localparam int unsigned cnt_w = $clog2(QUEUE_DEPTH);
  localparam logic [node_id_w-1:0] my_id = node_id_w'(NODE_ID);
  // queue count saturates one below the storage depth
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(QUEUE_DEPTH - 1);

  // bus decode
  logic             bus_sel;
  logic             bus_wr;
  logic             rd_start;
  logic             rd_ack_q;
  logic [2:0]       reg_sel;
  logic [31:0]      bus_dat_q;
  logic [31:0]      status_word;

  // incoming packet fields
  logic [node_id_w-1:0] in_rid;
  logic [node_id_w-1:0] in_tid;
  logic                 in_ack;

  // transmit side
  packet_t          tx_buf;
  logic             txp;
  logic             tx_insert;

  // receive side
  packet_t          net_nxt;
  packet_t          rx_head;
  logic             rx_push;
  logic             rx_pop;
  logic [cnt_w-1:0] rx_cnt;
  logic [cnt_w-1:0] rx_tap;

  // ========================================
  // receive queue
  // ========================================

  // oldest entry sits at tap count-1
  // an empty queue wraps the tap, data read then is meaningless
  assign rx_tap = rx_cnt - cnt_w'(1);

  noc_delay_line #(
    .WIDTH(packet_w),
    .DEPTH(QUEUE_DEPTH)
  ) u_rx_queue (
    .clk_i(clk_i),
    .ce_i (rx_push),
    .tap_i(rx_tap),
    .d_i  (net_i),
    .q_o  (rx_head)
  );

  // ========================================
  // ring stage decision
  // ========================================

  assign in_rid = net_i[rid_hi:rid_lo];
  assign in_tid = net_i[tid_hi:tid_lo];
  assign in_ack = net_i[ack_bit];

  always_comb begin
    // default is pass through, nothing queued
    net_nxt   = net_i;
    rx_push   = 1'b0;
    tx_insert = 1'b0;
    if (in_tid == my_id) begin
      // own packet came all the way round
      // broadcast is done, unicast keeps going
      if (in_rid == id_broadcast) begin
        net_nxt = '0;
      end
    end else if (in_rid == my_id) begin
      if (in_ack) begin
        // ack for an earlier send frees the slot
        if (txp) begin
          net_nxt   = tx_buf;
          tx_insert = 1'b1;
        end else begin
          net_nxt = '0;
        end
      end else begin
        // data for us, queue it and turn it into an ack
        rx_push                = 1'b1;
        net_nxt[rid_hi:rid_lo] = in_tid;
        net_nxt[tid_hi:tid_lo] = in_rid;
        net_nxt[ack_bit]       = 1'b1;
      end
    end else if (in_rid == id_broadcast) begin
      // someone else's broadcast, keep a copy and forward
      rx_push = 1'b1;
    end else if (in_rid == id_empty && txp) begin
      // free slot going by
      net_nxt   = tx_buf;
      tx_insert = 1'b1;
    end
  end

  // one register per hop
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      net_o <= '0;
    end else begin
      net_o <= net_nxt;
    end
  end

  // ========================================
  // bus interface
  // ========================================

  assign bus_sel = bus_cyc_i & bus_stb_i & bus_cs_i;
  assign bus_wr  = bus_sel & bus_we_i;
  assign reg_sel = bus_adr_i[reg_adr_hi:reg_adr_lo];

  // read side effects only on the first cycle of select
  assign rd_start = bus_sel & ~bus_we_i & ~rd_ack_q;

  // writes ack at once, reads one cycle later
  assign bus_ack_o = bus_sel & (bus_we_i | rd_ack_q);
  assign bus_dat_o = bus_dat_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ack_q <= 1'b0;
    end else begin
      rd_ack_q <= bus_sel & ~bus_we_i;
    end
  end

  // transmit buffer fill
  always_ff @(posedge clk_i) begin
    if (bus_wr) begin
      case (reg_sel)
        reg_word0: tx_buf[0*bus_w +: bus_w] <= bus_dat_i;
        reg_word1: tx_buf[1*bus_w +: bus_w] <= bus_dat_i;
        reg_word2: begin
          tx_buf[2*bus_w +: bus_w] <= bus_dat_i;
          // stamp our own id, never send an ack from software
          tx_buf[tid_hi:tid_lo]    <= my_id;
          tx_buf[ack_bit]          <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  // transmit pending flag
  // insertion wins, a second cmd write while pending is ignored
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      txp <= 1'b0;
    end else if (tx_insert) begin
      txp <= 1'b0;
    end else if (bus_wr && reg_sel == reg_cmd) begin
      txp <= 1'b1;
    end
  end

  // status layout: id, txp, count
  always_comb begin
    status_word                    = '0;
    status_word[st_id_hi:st_id_lo] = my_id;
    status_word[st_txp_bit]        = txp;
    status_word[st_cnt_w-1:0]      = st_cnt_w'(rx_cnt);
  end

  // read data registered, valid with ack
  always_ff @(posedge clk_i) begin
    if (rd_start) begin
      case (reg_sel)
        reg_word0:  bus_dat_q <= rx_head[0*bus_w +: bus_w];
        reg_word1:  bus_dat_q <= rx_head[1*bus_w +: bus_w];
        reg_word2:  bus_dat_q <= rx_head[2*bus_w +: bus_w];
        reg_status: bus_dat_q <= status_word;
        default:    bus_dat_q <= '0;
      endcase
    end
  end

  // ========================================
  // queue count
  // ========================================

  // pop of an empty queue does nothing
  assign rx_pop = rd_start && (reg_sel == reg_cmd) && (rx_cnt != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_cnt <= '0;
    end else if (rx_push && !rx_pop) begin
      // full queue drops its oldest entry instead
      if (rx_cnt != cnt_max) begin
        rx_cnt <= rx_cnt + cnt_w'(1);
      end
    end else if (!rx_push && rx_pop) begin
      rx_cnt <= rx_cnt - cnt_w'(1);
    end
  end

  // ========================================
  // checks
  // ========================================

  // count stays within the usable queue depth
  a_cnt_ceiling: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_cnt <= cnt_max);

  // an empty queue never wraps downward
  a_cnt_floor: assert property (@(posedge clk_i) disable iff (rst_i)
    (rx_cnt == '0) |=> (rx_cnt <= cnt_w'(1)));

  // no node on the ring may claim the broadcast id as source
  a_no_bcast_tid: assert property (@(posedge clk_i) disable iff (rst_i)
    net_o[tid_hi:tid_lo] != id_broadcast);

endmodule

/* noc_ring.sv */
`timescale 1ns/1ps

module noc_ring #(
  parameter int unsigned NUM_NODES   = 4,
  parameter int unsigned QUEUE_DEPTH = noc_pkg::queue_depth_default
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // one bus per node
  input  logic [NUM_NODES-1:0]      bus_cyc_i,
  input  logic [NUM_NODES-1:0]      bus_stb_i,
  input  logic [NUM_NODES-1:0]      bus_cs_i,
  input  logic [NUM_NODES-1:0]      bus_we_i,
  input  logic [NUM_NODES-1:0][31:0] bus_adr_i,
  input  logic [NUM_NODES-1:0][31:0] bus_dat_i,
  output logic [NUM_NODES-1:0]      bus_ack_o,
  output logic [NUM_NODES-1:0][31:0] bus_dat_o
);

  import noc_pkg::*;

  // ========================================
  // ring wiring
  // ========================================

  // ring_q[k] is the registered output of node k
  // each stage adds one cycle of latency
  packet_t ring_q [NUM_NODES];

  // ========================================
  // node instances
  // ========================================

  for (genvar k = 0; k < NUM_NODES; k++) begin : g_node
    // upstream neighbour, node 0 closes the loop from the last one
    localparam int unsigned prev = (k == 0) ? NUM_NODES - 1 : k - 1;

    // id 0 means empty slot, so numbering starts at 1
    noc_node_ctrl #(
      .NODE_ID    (k + 1),
      .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_node (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .bus_cyc_i(bus_cyc_i[k]),
      .bus_stb_i(bus_stb_i[k]),
      .bus_cs_i (bus_cs_i[k]),
      .bus_we_i (bus_we_i[k]),
      .bus_adr_i(bus_adr_i[k]),
      .bus_dat_i(bus_dat_i[k]),
      .bus_ack_o(bus_ack_o[k]),
      .bus_dat_o(bus_dat_o[k]),
      .net_i    (ring_q[prev]),
      .net_o    (ring_q[k])
    );
  end

endmodule

/* tb_noc_ring.sv */
`timescale 1ns/1ps

module tb_noc_ring;

  import noc_pkg::*;

  localparam int num_nodes   = 4;
  // bus cycles allowed before a missing ack counts as a hang
  localparam int ack_limit   = 8;
  // status reads allowed while waiting for a count or txp
  localparam int poll_limit  = 100;
  localparam int uni_count   = 8;
  localparam int burst_count = 5;

  logic                       clk_i;
  logic                       rst_i;
  logic [num_nodes-1:0]       bus_cyc;
  logic [num_nodes-1:0]       bus_stb;
  logic [num_nodes-1:0]       bus_cs;
  logic [num_nodes-1:0]       bus_we;
  logic [num_nodes-1:0][31:0] bus_adr;
  logic [num_nodes-1:0][31:0] bus_wdat;
  logic [num_nodes-1:0]       bus_ack;
  logic [num_nodes-1:0][31:0] bus_rdat;

  // reference model, one expected receive queue per node
  packet_t exp_q [num_nodes][$];

  int err_cnt;
  int check_cnt;
  int test_cnt;
  int test_fail_cnt;
  int base_err;
  bit hung;
  bit base_hung;

  noc_ring #(
    .NUM_NODES  (num_nodes),
    .QUEUE_DEPTH(queue_depth_default)
  ) DUT (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .bus_cyc_i(bus_cyc),
    .bus_stb_i(bus_stb),
    .bus_cs_i (bus_cs),
    .bus_we_i (bus_we),
    .bus_adr_i(bus_adr),
    .bus_dat_i(bus_wdat),
    .bus_ack_o(bus_ack),
    .bus_dat_o(bus_rdat)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // ========================================
  // checking and reporting
  // ========================================

  task automatic check_value(input string what, input logic [95:0] got,
                             input logic [95:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // later bus tasks return at once, so the run drains to its end quickly
  task automatic report_hang(input string why);
    $display("timeout at %0t ns: %s", $time, why);
    hung = 1'b1;
  endtask

  task automatic finish_test(input int num, input string name);
    test_cnt++;
    if (err_cnt == base_err && hung == base_hung) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      test_fail_cnt++;
      $display("test %0d %s: fail, %0d new errors", num, name, err_cnt - base_err);
    end
    base_err  = err_cnt;
    base_hung = hung;
  endtask

  // ========================================
  // bus access
  // ========================================

  // write acks in the select cycle, takes effect on the next edge
  task automatic bus_write(input int node, input logic [2:0] off, input logic [31:0] data);
    int waited;
    waited = 0;
    if (hung) return;
    @(posedge clk_i);
    bus_cyc[node]  <= 1'b1;
    bus_stb[node]  <= 1'b1;
    bus_cs[node]   <= 1'b1;
    bus_we[node]   <= 1'b1;
    bus_adr[node]  <= {27'd0, off, 2'b00};
    bus_wdat[node] <= data;
    @(negedge clk_i);
    while (!bus_ack[node] && waited < ack_limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!bus_ack[node]) begin
      report_hang($sformatf("node %0d never acknowledged a write", node + 1));
    end
    @(posedge clk_i);
    bus_cyc[node] <= 1'b0;
    bus_stb[node] <= 1'b0;
    bus_cs[node]  <= 1'b0;
    bus_we[node]  <= 1'b0;
  endtask

  // read ack comes one cycle after select, data valid with it
  task automatic bus_read(input int node, input logic [2:0] off, output logic [31:0] data);
    int waited;
    waited = 0;
    data   = '0;
    if (hung) return;
    @(posedge clk_i);
    bus_cyc[node] <= 1'b1;
    bus_stb[node] <= 1'b1;
    bus_cs[node]  <= 1'b1;
    bus_we[node]  <= 1'b0;
    bus_adr[node] <= {27'd0, off, 2'b00};
    @(negedge clk_i);
    while (!bus_ack[node] && waited < ack_limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!bus_ack[node]) begin
      report_hang($sformatf("node %0d never acknowledged a read", node + 1));
    end
    data = bus_rdat[node];
    @(posedge clk_i);
    bus_cyc[node] <= 1'b0;
    bus_stb[node] <= 1'b0;
    bus_cs[node]  <= 1'b0;
  endtask

  // every node gets the transmit command in the same cycle
  task automatic issue_cmd_all();
    int waited;
    waited = 0;
    if (hung) return;
    @(posedge clk_i);
    bus_cyc <= '1;
    bus_stb <= '1;
    bus_cs  <= '1;
    bus_we  <= '1;
    for (int n = 0; n < num_nodes; n++) begin
      bus_adr[n]  <= {27'd0, reg_cmd, 2'b00};
      bus_wdat[n] <= '0;
    end
    @(negedge clk_i);
    while (bus_ack != '1 && waited < ack_limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (bus_ack != '1) begin
      report_hang("not every node acknowledged the common transmit command");
    end
    @(posedge clk_i);
    bus_cyc <= '0;
    bus_stb <= '0;
    bus_cs  <= '0;
    bus_we  <= '0;
  endtask

  // ========================================
  // packet helpers
  // ========================================

  // tid and ack are left random, hardware has to overwrite them
  function automatic packet_t random_packet(input int rid);
    packet_t p;
    p = {$urandom, $urandom, $urandom};
    p[rid_hi:rid_lo] = 6'(rid);
    return p;
  endfunction

  // what a receiver should see: source id stamped, ack clear
  function automatic packet_t model_packet(input packet_t raw, input int src);
    packet_t p;
    p = raw;
    p[tid_hi:tid_lo] = 6'(src + 1);
    p[ack_bit]       = 1'b0;
    return p;
  endfunction

  function automatic int pick_other(input int node);
    return (node + 1 + int'($urandom_range(num_nodes - 2, 0))) % num_nodes;
  endfunction

  task automatic load_packet(input int src, input packet_t raw);
    bus_write(src, reg_word0, raw[31:0]);
    bus_write(src, reg_word1, raw[63:32]);
    bus_write(src, reg_word2, raw[95:64]);
  endtask

  task automatic send_packet(input int src, input packet_t raw);
    load_packet(src, raw);
    bus_write(src, reg_cmd, 32'd0);
  endtask

  // head of queue first, then the pop
  task automatic pop_packet(input int node, output packet_t pkt);
    logic [31:0] w;
    pkt = '0;
    bus_read(node, reg_word0, w);
    pkt[31:0] = w;
    bus_read(node, reg_word1, w);
    pkt[63:32] = w;
    bus_read(node, reg_word2, w);
    pkt[95:64] = w;
    bus_read(node, reg_cmd, w);
  endtask

  task automatic wait_count(input int node, input int exp_cnt);
    logic [31:0] st;
    int polls;
    polls = 0;
    if (hung) return;
    bus_read(node, reg_status, st);
    while (int'(st[5:0]) != exp_cnt && polls < poll_limit && !hung) begin
      bus_read(node, reg_status, st);
      polls++;
    end
    if (!hung && int'(st[5:0]) != exp_cnt) begin
      report_hang($sformatf("node %0d queue count stayed at %0d, expected %0d",
                            node + 1, st[5:0], exp_cnt));
    end
  endtask

  task automatic wait_tx_idle(input int node);
    logic [31:0] st;
    int polls;
    polls = 0;
    if (hung) return;
    bus_read(node, reg_status, st);
    while (st[25] && polls < poll_limit && !hung) begin
      bus_read(node, reg_status, st);
      polls++;
    end
    if (!hung && st[25]) begin
      report_hang($sformatf("node %0d never inserted its pending packet", node + 1));
    end
  endtask

  task automatic check_count(input int node);
    logic [31:0] st;
    bus_read(node, reg_status, st);
    check_value($sformatf("node %0d queue count", node + 1),
                96'(st[5:0]), 96'(exp_q[node].size()));
  endtask

  // ========================================
  // test sequence
  // ========================================

  initial begin
    logic [31:0] word;
    packet_t     raw;
    packet_t     got;
    packet_t     exp_pkt;
    int          src;
    int          dst;
    int          cnt;
    bit          found;

    clk_i     = 1'b0;
    rst_i     = 1'b1;
    bus_cyc   = '0;
    bus_stb   = '0;
    bus_cs    = '0;
    bus_we    = '0;
    bus_adr   = '0;
    bus_wdat  = '0;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    test_fail_cnt = 0;
    base_err  = 0;
    hung      = 1'b0;
    base_hung = 1'b0;
    word      = $urandom(74664);

    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    // 1: idle ring, empty queues, words readable
    for (int n = 0; n < num_nodes; n++) begin
      bus_read(n, reg_status, word);
      check_value($sformatf("node %0d status id", n + 1), 96'(word[31:26]), 96'(n + 1));
      check_value($sformatf("node %0d status txp", n + 1), 96'(word[25]), 96'(0));
      check_value($sformatf("node %0d status count", n + 1), 96'(word[5:0]), 96'(0));
      bus_read(n, reg_word0, word);
      bus_read(n, reg_word1, word);
      bus_read(n, reg_word2, word);
    end
    finish_test(1, "reset state");

    // 2: unicast, one at a time
    for (int i = 0; i < uni_count; i++) begin
      src     = int'($urandom_range(num_nodes - 1, 0));
      dst     = pick_other(src);
      raw     = random_packet(dst + 1);
      exp_pkt = model_packet(raw, src);
      exp_q[dst].push_back(exp_pkt);
      send_packet(src, raw);
      wait_count(dst, exp_q[dst].size());
      pop_packet(dst, got);
      exp_pkt = exp_q[dst].pop_front();
      check_value($sformatf("unicast %0d to node %0d", i, dst + 1), got, exp_pkt);
      check_value("unicast ack bit", 96'(got[ack_bit]), 96'(0));
      wait_tx_idle(src);
      check_count(dst);
    end
    finish_test(2, "random unicast");

    // 3: broadcast reaches everyone except the source, once
    src     = int'($urandom_range(num_nodes - 1, 0));
    raw     = random_packet(int'(id_broadcast));
    exp_pkt = model_packet(raw, src);
    for (int n = 0; n < num_nodes; n++) begin
      if (n != src) exp_q[n].push_back(exp_pkt);
    end
    send_packet(src, raw);
    for (int n = 0; n < num_nodes; n++) begin
      wait_count(n, exp_q[n].size());
    end
    wait_tx_idle(src);
    // two full laps, any leftover copy would have landed by now
    repeat (2 * num_nodes) @(posedge clk_i);
    for (int n = 0; n < num_nodes; n++) begin
      check_count(n);
    end
    for (int n = 0; n < num_nodes; n++) begin
      if (n != src) begin
        pop_packet(n, got);
        exp_pkt = exp_q[n].pop_front();
        check_value($sformatf("broadcast copy at node %0d", n + 1), got, exp_pkt);
      end
    end
    finish_test(3, "broadcast");

    // 4: queue order, several arrivals before any pop
    dst = int'($urandom_range(num_nodes - 1, 0));
    for (int i = 0; i < burst_count; i++) begin
      src = pick_other(dst);
      raw = random_packet(dst + 1);
      exp_q[dst].push_back(model_packet(raw, src));
      send_packet(src, raw);
      wait_count(dst, exp_q[dst].size());
    end
    for (int i = 0; i < burst_count; i++) begin
      pop_packet(dst, got);
      exp_pkt = exp_q[dst].pop_front();
      check_value($sformatf("queued packet %0d at node %0d", i, dst + 1), got, exp_pkt);
      check_count(dst);
    end
    finish_test(4, "queue order");

    // 5: all nodes transmit together
    for (int n = 0; n < num_nodes; n++) begin
      dst = pick_other(n);
      raw = random_packet(dst + 1);
      exp_q[dst].push_back(model_packet(raw, n));
      load_packet(n, raw);
    end
    issue_cmd_all();
    for (int n = 0; n < num_nodes; n++) begin
      wait_count(n, exp_q[n].size());
    end
    for (int n = 0; n < num_nodes; n++) begin
      wait_tx_idle(n);
    end
    // arrival order between sources is free, so match against any entry
    for (int n = 0; n < num_nodes; n++) begin
      cnt = exp_q[n].size();
      for (int j = 0; j < cnt; j++) begin
        pop_packet(n, got);
        found = 1'b0;
        for (int k = 0; k < exp_q[n].size(); k++) begin
          if (!found && exp_q[n][k] == got) begin
            exp_q[n].delete(k);
            found = 1'b1;
          end
        end
        check_value($sformatf("node %0d packet %h expected once", n + 1, got),
                    96'(found), 96'(1));
      end
      check_value($sformatf("node %0d unmatched model entries", n + 1),
                  96'(exp_q[n].size()), 96'(0));
      check_count(n);
    end
    finish_test(5, "all nodes at once");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0 && !hung) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* noc_ring.f */
noc_pkg.sv
noc_delay_line.sv
noc_node_ctrl.sv
noc_ring.sv
tb_noc_ring.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ring testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_noc_ring -f noc_ring.f -o sim_noc_ring \
  || { echo "build failed"; exit 1; }

./obj_dir/sim_noc_ring | tee /dev/stderr | grep -x "TEST OK" > /dev/null \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
